//--- Makefile
TB  := mem_port_tb
BIN := obj_dir/V$(TB)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

$(BIN): all.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert --top-module $(TB) -f all.f

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- all.f
src/mem_port_pkg.sv
src/beat_counter.sv
src/line_buffer.sv
src/line_arbiter.sv
src/mem_port.sv
tests/mem_port_chk.sv
tests/mem_port_tb.sv

//--- src/beat_counter.sv
`timescale 1ns/1ns

module beat_counter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear_i,
    input  logic                     advance_i,
    output mem_port_pkg::beat_idx_t  beat_idx_o,
    output logic                     last_beat_o
);
    import mem_port_pkg::*;

    beat_idx_t count_q;

    // wraps at LINE_BEATS through the width of beat_idx_t
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;  // clear wins over advance
        end else if (advance_i) begin
            count_q <= count_q + beat_idx_t'(1);
        end
    end

    assign beat_idx_o  = count_q;
    assign last_beat_o = (count_q == beat_idx_t'(LINE_BEATS - 1));

endmodule : beat_counter

//--- src/line_arbiter.sv
`timescale 1ns/1ns

module line_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_read_i,
    input  logic                 d_read_i,
    input  logic                 d_write_i,
    input  mem_port_pkg::addr_t  i_addr_i,
    input  mem_port_pkg::addr_t  d_addr_i,
    input  logic                 last_beat_i,
    input  logic                 bmem_resp_i,
    output logic                 beat_clear_o,
    output logic                 beat_advance_o,
    output logic                 capture_en_o,
    output mem_port_pkg::addr_t  bmem_address_o,
    output logic                 bmem_read_o,
    output logic                 bmem_write_o,
    output logic                 i_resp_o,
    output logic                 d_resp_o
);
    import mem_port_pkg::*;

    arb_state_t state_q;
    arb_state_t state_d;
    logic       grant_data_q;  // side in flight, doubles as last served
    logic       grant_data_d;
    addr_t      addr_q;        // aligned line address of the winner
    addr_t      sel_addr;
    logic       i_req;
    logic       d_req;
    logic       pick_data;

    assign i_req = i_read_i;
    assign d_req = d_read_i | d_write_i;

    // on a tie the side not served last wins
    assign pick_data = d_req & (~i_req | ~grant_data_q);
    assign sel_addr  = pick_data ? d_addr_i : i_addr_i;

    always_comb begin
        state_d        = state_q;
        grant_data_d   = grant_data_q;
        beat_advance_o = 1'b0;
        capture_en_o   = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (i_req || d_req) begin
                    grant_data_d = pick_data;
                    if (pick_data && d_write_i) begin
                        state_d = ST_WR_BURST;
                    end else begin
                        state_d = ST_RD_REQ;
                    end
                end
            end
            ST_RD_REQ: begin
                state_d = ST_RD_WAIT;  // strobe lasts one cycle
            end
            ST_RD_WAIT: begin
                if (bmem_resp_i) begin
                    capture_en_o   = 1'b1;
                    beat_advance_o = 1'b1;
                    if (last_beat_i) begin
                        state_d = ST_DONE;
                    end
                end
            end
            ST_WR_BURST: begin
                beat_advance_o = 1'b1;  // one beat per cycle, no stalls
                if (last_beat_i) begin
                    state_d = ST_WR_WAIT;
                end
            end
            ST_WR_WAIT: begin
                if (bmem_resp_i) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE;  // requester drops its request here
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= ST_IDLE;
            grant_data_q <= 1'b1;  // instruction wins the first tie
        end else begin
            state_q      <= state_d;
            grant_data_q <= grant_data_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && (i_req || d_req)) begin
            addr_q <= {sel_addr[$bits(addr_t)-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
        end
    end

    assign beat_clear_o   = (state_q == ST_IDLE);  // counter starts each burst at 0
    assign bmem_address_o = addr_q;
    assign bmem_read_o    = (state_q == ST_RD_REQ);
    assign bmem_write_o   = (state_q == ST_WR_BURST);
    assign i_resp_o       = (state_q == ST_DONE) & ~grant_data_q;
    assign d_resp_o       = (state_q == ST_DONE) & grant_data_q;

endmodule : line_arbiter

//--- src/line_buffer.sv
`timescale 1ns/1ns

module line_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     capture_en_i,
    input  mem_port_pkg::beat_idx_t  beat_idx_i,
    input  mem_port_pkg::beat_t      bmem_rdata_i,
    input  mem_port_pkg::line_t      wr_line_i,
    output mem_port_pkg::line_t      rd_line_o,
    output mem_port_pkg::beat_t      bmem_wdata_o
);
    import mem_port_pkg::*;

    localparam int BEAT_BITS = $bits(beat_t);

    line_t line_q;                  // read line being assembled
    beat_t wr_beats [LINE_BEATS];   // write line split into beats

    // read path, one beat slot per memory resp
    always_ff @(posedge clk) begin
        if (rst) begin
            line_q <= '0;
        end else if (capture_en_i) begin
            line_q[beat_idx_i*BEAT_BITS +: BEAT_BITS] <= bmem_rdata_i;
        end
    end

    assign rd_line_o = line_q;

    // write path, beat 0 at the low end
    always_comb begin
        for (int k = 0; k < LINE_BEATS; k++) begin
            wr_beats[k] = wr_line_i[k*BEAT_BITS +: BEAT_BITS];
        end
    end

    assign bmem_wdata_o = wr_beats[beat_idx_i];

endmodule : line_buffer

//--- src/mem_port.sv
`timescale 1ns/1ns

module mem_port (
    input  logic                 clk,
    input  logic                 rst,
    // instruction side, read only
    input  logic                 i_read_i,
    input  mem_port_pkg::addr_t  i_addr_i,
    output mem_port_pkg::line_t  i_rdata_o,
    output logic                 i_resp_o,
    // data side
    input  logic                 d_read_i,
    input  logic                 d_write_i,
    input  mem_port_pkg::addr_t  d_addr_i,
    input  mem_port_pkg::line_t  d_wdata_i,
    output mem_port_pkg::line_t  d_rdata_o,
    output logic                 d_resp_o,
    // burst memory bus
    output mem_port_pkg::addr_t  bmem_address_o,
    output logic                 bmem_read_o,
    output logic                 bmem_write_o,
    output mem_port_pkg::beat_t  bmem_wdata_o,
    input  mem_port_pkg::beat_t  bmem_rdata_i,
    input  logic                 bmem_resp_i
);
    import mem_port_pkg::*;

    logic      beat_clear;
    logic      beat_advance;
    logic      capture_en;
    logic      last_beat;
    beat_idx_t beat_idx;
    line_t     rd_line;

    line_arbiter line_arbiter_i (
        .clk            (clk),
        .rst            (rst),
        .i_read_i       (i_read_i),
        .d_read_i       (d_read_i),
        .d_write_i      (d_write_i),
        .i_addr_i       (i_addr_i),
        .d_addr_i       (d_addr_i),
        .last_beat_i    (last_beat),
        .bmem_resp_i    (bmem_resp_i),
        .beat_clear_o   (beat_clear),
        .beat_advance_o (beat_advance),
        .capture_en_o   (capture_en),
        .bmem_address_o (bmem_address_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .i_resp_o       (i_resp_o),
        .d_resp_o       (d_resp_o)
    );

    beat_counter beat_counter_i (
        .clk         (clk),
        .rst         (rst),
        .clear_i     (beat_clear),
        .advance_i   (beat_advance),
        .beat_idx_o  (beat_idx),
        .last_beat_o (last_beat)
    );

    line_buffer line_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .capture_en_i (capture_en),
        .beat_idx_i   (beat_idx),
        .bmem_rdata_i (bmem_rdata_i),
        .wr_line_i    (d_wdata_i),     // only the data side writes
        .rd_line_o    (rd_line),
        .bmem_wdata_o (bmem_wdata_o)
    );

    // shared read line, valid with the matching resp
    assign i_rdata_o = rd_line;
    assign d_rdata_o = rd_line;

endmodule : mem_port

//--- src/mem_port_pkg.sv
package mem_port_pkg;

    // byte address on both the client side and the burst bus
    typedef logic [31:0] addr_t;

    // one beat of the burst memory bus
    typedef logic [63:0] beat_t;

    // a whole cache line, beat k sits at bits 64k+63 down to 64k
    typedef logic [255:0] line_t;

    // which beat of a line is on the bus
    typedef logic [1:0] beat_idx_t;

    localparam int LINE_BEATS       = 4;  // beats per line
    localparam int LINE_OFFSET_BITS = 5;  // byte offset within a line

    // arbiter and burst sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,      // waiting for a request
        ST_RD_REQ,    // one-cycle read strobe to memory
        ST_RD_WAIT,   // collecting read beats
        ST_WR_BURST,  // driving the four write beats
        ST_WR_WAIT,   // waiting for write ack
        ST_DONE       // client resp cycle
    } arb_state_t;

endpackage : mem_port_pkg

//--- tests/mem_port_chk.sv
`timescale 1ns/1ns

module mem_port_chk (
    input logic clk,
    input logic rst,
    input logic i_read_i,
    input logic d_read_i,
    input logic d_write_i,
    input logic i_resp_o,
    input logic d_resp_o,
    input logic bmem_read_o,
    input logic bmem_write_o
);
    int fail_cnt = 0;  // failures seen so far

    bus_one_dir: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read_o && bmem_write_o))
        else begin
            $error("bmem read and write high together");
            fail_cnt++;
        end

    resp_one_side: assert property (@(posedge clk) disable iff (rst)
        !(i_resp_o && d_resp_o))
        else begin
            $error("both resps high together");
            fail_cnt++;
        end

    // the read strobe is a single cycle
    read_strobe: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |=> !bmem_read_o)
        else begin
            $error("bmem read longer than one cycle");
            fail_cnt++;
        end

    i_resp_req: assert property (@(posedge clk) disable iff (rst)
        i_resp_o |-> i_read_i)
        else begin
            $error("instruction resp without a request");
            fail_cnt++;
        end

    d_resp_req: assert property (@(posedge clk) disable iff (rst)
        d_resp_o |-> (d_read_i || d_write_i))
        else begin
            $error("data resp without a request");
            fail_cnt++;
        end

endmodule : mem_port_chk

bind mem_port mem_port_chk mem_port_chk_i (.*);

//--- tests/mem_port_tb.sv
`timescale 1ns/1ns

module mem_port_tb;
    import mem_port_pkg::*;

    localparam int N_IREAD = 20;
    localparam int N_WRRD  = 10;
    localparam int N_TIE   = 8;
    localparam int N_MIX   = 200;
    // about 40 cycles per request, a tied or mixed round can carry two
    localparam int TIMEOUT_CYCLES = (N_IREAD + 2 * N_WRRD + 3 * N_TIE + 2 * N_MIX) * 40;

    logic  clk;
    logic  rst;
    logic  i_read_i;
    addr_t i_addr_i;
    line_t i_rdata_o;
    logic  i_resp_o;
    logic  d_read_i;
    logic  d_write_i;
    addr_t d_addr_i;
    line_t d_wdata_i;
    line_t d_rdata_o;
    logic  d_resp_o;
    addr_t bmem_address_o;
    logic  bmem_read_o;
    logic  bmem_write_o;
    beat_t bmem_wdata_o;
    beat_t bmem_rdata_i;
    logic  bmem_resp_i;

    line_t mem [16];      // memory model, filled from the write bursts
    line_t exp_mem [16];  // scoreboard copy
    int    seed = 32'h4ce0_d86d;
    int    errors = 0;
    int    err_mark = 0;
    int    cycle_cnt = 0;
    int    served_i = 0;
    int    served_d = 0;
    logic  last_data;  // 1 when the data side was served last
    logic  win_data;   // predicted owner of the burst in flight

    mem_port mem_port_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin : watchdog
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, a response never came", cycle_cnt);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic coin();
        return ($random(seed) & 1) != 0;
    endfunction

    function automatic addr_t random_addr();
        return addr_t'($random(seed));
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int k = 0; k < 8; k++) begin
            l[k*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s finished, %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    // raise the requests, hold each one until its resp, then drop it
    task automatic run_request(input logic want_i, input logic want_d, input logic wr,
                               input addr_t ia, input addr_t da, input line_t wd);
        logic pend_i;
        logic pend_d;
        pend_i = want_i;
        pend_d = want_d;
        @(posedge clk);
        i_read_i  <= want_i;
        i_addr_i  <= ia;
        d_read_i  <= want_d & ~wr;
        d_write_i <= want_d & wr;
        d_addr_i  <= da;
        d_wdata_i <= wd;
        while (pend_i || pend_d) begin
            @(negedge clk);
            if (i_resp_o) begin
                check_flag(win_data, 1'b0, "instruction resp out of turn");
                check_line(i_rdata_o, exp_mem[ia[8:5]], "instruction read line");
                last_data = 1'b0;
                served_i++;
                pend_i = 1'b0;
            end
            if (d_resp_o) begin
                check_flag(win_data, 1'b1, "data resp out of turn");
                if (wr) begin
                    check_line(mem[da[8:5]], wd, "write beats stored by memory");
                    exp_mem[da[8:5]] = wd;
                end else begin
                    check_line(d_rdata_o, exp_mem[da[8:5]], "data read line");
                end
                last_data = 1'b1;
                served_d++;
                pend_d = 1'b0;
            end
            @(posedge clk);
            if (!pend_i) begin
                i_read_i <= 1'b0;
            end
            if (!pend_d) begin
                d_read_i  <= 1'b0;
                d_write_i <= 1'b0;
            end
        end
    endtask

    initial begin : memory_model
        line_t wline;
        int    gap;
        bmem_resp_i  <= 1'b0;
        bmem_rdata_i <= '0;
        forever begin
            @(negedge clk);
            if (bmem_read_o || bmem_write_o) begin
                if (i_read_i && (d_read_i || d_write_i)) begin
                    win_data = ~last_data;  // both waiting, the other side gets its turn
                end else begin
                    win_data = d_read_i | d_write_i;
                end
                check_addr(bmem_address_o,
                           {(win_data ? d_addr_i[31:5] : i_addr_i[31:5]), 5'b0},
                           "burst address");
            end
            if (bmem_read_o) begin
                for (int k = 0; k < LINE_BEATS; k++) begin
                    gap = {$random(seed)} % 4;
                    repeat (gap) begin
                        @(posedge clk);
                        bmem_resp_i <= 1'b0;
                    end
                    @(posedge clk);
                    bmem_resp_i  <= 1'b1;
                    bmem_rdata_i <= mem[bmem_address_o[8:5]][k*64 +: 64];  // lowest beat first
                end
                @(posedge clk);
                bmem_resp_i <= 1'b0;
            end else if (bmem_write_o) begin
                for (int k = 0; k < LINE_BEATS; k++) begin
                    if (!bmem_write_o) begin
                        errors++;
                        $display("write burst stopped after %0d beats", k);
                    end
                    wline[k*64 +: 64] = bmem_wdata_o;
                    @(negedge clk);
                end
                mem[bmem_address_o[8:5]] = wline;
                gap = 1 + {$random(seed)} % 4;
                repeat (gap) @(posedge clk);
                bmem_resp_i <= 1'b1;
                @(posedge clk);
                bmem_resp_i <= 1'b0;
            end
        end
    end

    initial begin : main
        addr_t a;
        int    mode;
        int    assert_fails;
        rst       <= 1'b1;
        i_read_i  <= 1'b0;
        i_addr_i  <= '0;
        d_read_i  <= 1'b0;
        d_write_i <= 1'b0;
        d_addr_i  <= '0;
        d_wdata_i <= '0;
        last_data = 1'b1;
        for (int n = 0; n < 16; n++) begin
            mem[n] = random_line();
            exp_mem[n] = mem[n];
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        repeat (10) begin
            @(negedge clk);
            check_flag(bmem_read_o | bmem_write_o | i_resp_o | d_resp_o, 1'b0, "idle outputs");
        end
        report_test(1, "idle after reset");

        for (int n = 0; n < N_IREAD; n++) begin
            run_request(1'b1, 1'b0, 1'b0, random_addr(), '0, '0);
        end
        report_test(2, "instruction reads");

        for (int n = 0; n < N_WRRD; n++) begin
            a = random_addr();
            run_request(1'b0, 1'b1, 1'b1, '0, a, random_line());
            run_request(1'b0, 1'b1, 1'b0, '0, a, '0);
        end
        report_test(3, "data write then read");

        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        last_data = 1'b1;  // instruction wins the first tie
        for (int n = 0; n < N_TIE; n++) begin
            if (n > 0 && coin()) begin
                run_request(1'b1, 1'b0, 1'b0, random_addr(), '0, '0);
            end
            run_request(1'b1, 1'b1, coin(), random_addr(), random_addr(), random_line());
        end
        report_test(4, "simultaneous requests");

        served_i = 0;
        served_d = 0;
        for (int n = 0; n < N_MIX; n++) begin
            mode = {$random(seed)} % 3;  // 0 instruction, 1 data, 2 both
            run_request(mode != 1, mode != 0, coin(), random_addr(), random_addr(),
                        random_line());
        end
        if (served_i == 0 || served_d == 0) begin
            errors++;
            $display("random mix left a side unserved: %0d instruction, %0d data",
                     served_i, served_d);
        end
        report_test(5, "random mix");

        assert_fails = mem_port_i.mem_port_chk_i.fail_cnt;
        $display("%0d errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : mem_port_tb
